// File: verilog/board_pkg.sv
// Board widths, bit positions, game reset length and input structs
package board_pkg;

    // Board joystick words and the game side view of them
    localparam int JOY_W      = 16;
    localparam int GAME_JOY_W = 10;
    localparam int START1_BIT = 6;
    localparam int START2_BIT = 7;
    localparam int COIN_BIT   = 8;
    localparam int PAUSE_BIT  = 9;

    localparam logic INPUTS_ACTIVE_LOW = 1'b1; // Game reads a pressed input as 0

    // Game reset stretch after the last trigger
    localparam int GAME_RST_HOLD  = 256;
    localparam int GAME_RST_CNT_W = $clog2(GAME_RST_HOLD);

    // OSD status word layout
    localparam int STATUS_W           = 32;
    localparam int STATUS_ROT_BIT     = 2;
    localparam int STATUS_FM_OFF_BIT  = 8;
    localparam int STATUS_PSG_OFF_BIT = 9;
    localparam int STATUS_TEST_BIT    = 10;
    localparam int STATUS_PAUSE_BIT   = 11;
    localparam int STATUS_FLIP_BIT    = 12;

    localparam int GFX_LAYERS = 4;

    // Both board joysticks, player 1 in the low word
    typedef struct packed {
        logic [JOY_W-1:0] joy2;
        logic [JOY_W-1:0] joy1;
    } joy_pair_t;

    // Keys as they come out of the keyboard decoder
    typedef struct packed {
        logic [GAME_JOY_W-1:0] joy1;
        logic [GAME_JOY_W-1:0] joy2;
        logic [1:0]            start;
        logic [1:0]            coin;
        logic                  reset;   // Soft reset of the game
        logic                  pause;
        logic                  service;
        logic [GFX_LAYERS-1:0] gfx;     // Layer enable toggles
    } key_state_t;

endpackage

// File: verilog/dip_if.sv
// Interface for the decoded board settings
interface dip_if;

    logic rot_control;   // Rotate controls for vertical games
    logic flip;          // Screen flip, a change restarts the game
    logic test;
    logic status_pause;  // Pause forced from the OSD
    logic enable_fm;
    logic enable_psg;

    modport decoder (
        output rot_control,
        output flip,
        output test,
        output status_pause,
        output enable_fm,
        output enable_psg
    );

    // Control only needs flip tracking and the forced pause
    modport ctrl (
        input flip,
        input status_pause
    );

    modport mapper (
        input rot_control
    );

endinterface

// File: verilog/sample_sync.sv
// Two-stage input synchronizer with per-bit rising-edge flags
module sample_sync #(
    parameter type payload_t = logic
) (
    input  logic     clk_sys,
    input  logic     rst,
    input  payload_t din,
    output payload_t level,
    output payload_t rise
);

    payload_t meta; // First stage, may go metastable

    // Rise is computed from the stage about to enter level, so both
    // change on the same edge and rise lasts one cycle
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            meta  <= '0;
            level <= '0;
            rise  <= '0;
        end else begin
            meta  <= din;
            level <= meta;
            rise  <= payload_t'(meta & ~level); // Newly set bits
        end
    end

endmodule

// File: verilog/dip_decode.sv
// Registered decode of the OSD status word into board settings
module dip_decode import board_pkg::*; (
    input  logic                clk_sys,
    input  logic                rst,
    input  logic [STATUS_W-1:0] status,
    dip_if.decoder              dip
);

    logic rot_q;
    logic flip_q;
    logic test_q;
    logic pause_q;
    logic fm_en_q;
    logic psg_en_q;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            rot_q    <= 1'b0;
            flip_q   <= 1'b0;
            test_q   <= 1'b0;
            pause_q  <= 1'b0;
            fm_en_q  <= 1'b1;   // Sound on by default
            psg_en_q <= 1'b1;
        end else begin
            rot_q    <= status[STATUS_ROT_BIT];
            flip_q   <= status[STATUS_FLIP_BIT];
            test_q   <= status[STATUS_TEST_BIT];
            pause_q  <= status[STATUS_PAUSE_BIT];
            // OSD stores the sound chips as disable bits
            fm_en_q  <= ~status[STATUS_FM_OFF_BIT];
            psg_en_q <= ~status[STATUS_PSG_OFF_BIT];
        end
    end

    assign dip.rot_control  = rot_q;
    assign dip.flip         = flip_q;
    assign dip.test         = test_q;
    assign dip.status_pause = pause_q;
    assign dip.enable_fm    = fm_en_q;
    assign dip.enable_psg   = psg_en_q;

endmodule

// File: verilog/input_mapper.sv
// Merge of joystick and key inputs with rotation and active-low output
module input_mapper import board_pkg::*; (
    input  logic                  clk_sys,
    input  logic                  rst,
    input  joy_pair_t             joy,     // Synchronized board joysticks
    input  key_state_t            key,     // Synchronized keys
    dip_if.mapper                 dip,
    output logic [GAME_JOY_W-1:0] game_joystick1,
    output logic [GAME_JOY_W-1:0] game_joystick2,
    output logic [1:0]            game_coin,
    output logic [1:0]            game_start,
    output logic                  game_service
);

    // Quarter turn of the direction bits, buttons untouched
    function automatic logic [GAME_JOY_W-1:0] apply_rot(
        input logic [GAME_JOY_W-1:0] j,
        input logic                  rot
    );
        logic [GAME_JOY_W-1:0] r;
        r = j;
        if (rot) begin
            r[3] = j[0];
            r[2] = j[1];
            r[1] = j[3];
            r[0] = j[2];
        end
        return r;
    endfunction

    logic [GAME_JOY_W-1:0] joy1_mix;
    logic [GAME_JOY_W-1:0] joy2_mix;
    logic [1:0]            coin_mix;
    logic [1:0]            start_mix;

    assign joy1_mix = apply_rot(joy.joy1[GAME_JOY_W-1:0] | key.joy1, dip.rot_control);
    assign joy2_mix = apply_rot(joy.joy2[GAME_JOY_W-1:0] | key.joy2, dip.rot_control);

    // Coin n comes from joystick n+1 only
    assign coin_mix = {joy.joy2[COIN_BIT], joy.joy1[COIN_BIT]} | key.coin;

    // Either joystick can start either player
    assign start_mix = {joy.joy1[START2_BIT], joy.joy1[START1_BIT]}
                     | {joy.joy2[START2_BIT], joy.joy2[START1_BIT]}
                     | key.start;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            // Idle value, nothing pressed
            game_joystick1 <= {GAME_JOY_W{INPUTS_ACTIVE_LOW}};
            game_joystick2 <= {GAME_JOY_W{INPUTS_ACTIVE_LOW}};
            game_coin      <= {2{INPUTS_ACTIVE_LOW}};
            game_start     <= {2{INPUTS_ACTIVE_LOW}};
            game_service   <= INPUTS_ACTIVE_LOW;
        end else begin
            game_joystick1 <= joy1_mix ^ {GAME_JOY_W{INPUTS_ACTIVE_LOW}};
            game_joystick2 <= joy2_mix ^ {GAME_JOY_W{INPUTS_ACTIVE_LOW}};
            game_coin      <= coin_mix ^ {2{INPUTS_ACTIVE_LOW}};
            game_start     <= start_mix ^ {2{INPUTS_ACTIVE_LOW}};
            game_service   <= key.service ^ INPUTS_ACTIVE_LOW;
        end
    end

endmodule

// File: verilog/board_ctrl.sv
// Game reset sequencer with pause and graphics layer toggles
module board_ctrl import board_pkg::*; (
    input  logic                  clk_sys,
    input  logic                  rst,
    input  logic                  rst_req,
    input  logic                  downloading,
    input  key_state_t            key_rise,
    input  joy_pair_t             joy_rise,
    dip_if.ctrl                   dip,
    output logic                  game_rst,
    output logic [GFX_LAYERS-1:0] gfx_en,
    output logic                  dip_pause
);

    logic [GAME_RST_CNT_W-1:0] rst_cnt;
    logic                      last_flip;
    logic                      flip_chg;
    logic                      soft_rst;
    logic                      rst_trig;
    logic                      pause_hit;
    logic                      game_pause;

    // Reset key acts once per press
    assign soft_rst = key_rise.reset;

    // Flipping the screen restarts the game
    assign flip_chg = dip.flip != last_flip;

    assign rst_trig = rst | downloading | rst_req | flip_chg | soft_rst;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            last_flip <= 1'b0;
        end else begin
            last_flip <= dip.flip;
        end
    end

    // Count restarts on every trigger, game_rst drops once the count
    // has covered GAME_RST_HOLD quiet cycles
    always_ff @(posedge clk_sys) begin
        if (rst_trig) begin
            rst_cnt  <= '0;
            game_rst <= 1'b1;
        end else if (rst_cnt != GAME_RST_CNT_W'(GAME_RST_HOLD - 1)) begin
            rst_cnt  <= rst_cnt + 1'b1;
            game_rst <= 1'b1;
        end else begin
            game_rst <= 1'b0;   // Hold over, counter parks here
        end
    end

    // Pause from the keyboard or from either joystick
    assign pause_hit = key_rise.pause
                     | joy_rise.joy1[PAUSE_BIT]
                     | joy_rise.joy2[PAUSE_BIT];

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_pause <= 1'b0;
            gfx_en     <= '1;   // All layers visible
        end else begin
            if (pause_hit) begin
                game_pause <= ~game_pause;
            end
            gfx_en <= gfx_en ^ key_rise.gfx; // One toggle per key press
        end
    end

    // Active low towards the game
    assign dip_pause = ~(game_pause | dip.status_pause);

endmodule

// File: verilog/board_top.sv
// Board input and reset section top level
module board_top import board_pkg::*; (
    input  logic                  clk_sys,
    input  logic                  rst,
    input  logic                  rst_req,
    input  logic                  downloading,
    input  joy_pair_t             board_joystick,
    input  key_state_t            keys,
    input  logic [STATUS_W-1:0]   status,
    output logic                  game_rst,
    output logic [GAME_JOY_W-1:0] game_joystick1,
    output logic [GAME_JOY_W-1:0] game_joystick2,
    output logic [1:0]            game_coin,
    output logic [1:0]            game_start,
    output logic                  game_service,
    output logic [GFX_LAYERS-1:0] gfx_en,
    output logic                  dip_pause,
    output logic                  dip_flip,
    output logic                  dip_test,
    output logic                  enable_fm,
    output logic                  enable_psg
);

    joy_pair_t  joy_level;
    joy_pair_t  joy_rise;
    key_state_t key_level;
    key_state_t key_rise;

    dip_if dip_bus ();

    // Board joysticks come straight from pins
    sample_sync #(
        .payload_t (joy_pair_t)
    ) joy_sync_i (
        .clk_sys (clk_sys),
        .rst     (rst),
        .din     (board_joystick),
        .level   (joy_level),
        .rise    (joy_rise)
    );

    sample_sync #(
        .payload_t (key_state_t)
    ) key_sync_i (
        .clk_sys (clk_sys),
        .rst     (rst),
        .din     (keys),
        .level   (key_level),
        .rise    (key_rise)
    );

    dip_decode dip_decode_i (
        .clk_sys (clk_sys),
        .rst     (rst),
        .status  (status),
        .dip     (dip_bus.decoder)
    );

    input_mapper input_mapper_i (
        .clk_sys        (clk_sys),
        .rst            (rst),
        .joy            (joy_level),
        .key            (key_level),
        .dip            (dip_bus.mapper),
        .game_joystick1 (game_joystick1),
        .game_joystick2 (game_joystick2),
        .game_coin      (game_coin),
        .game_start     (game_start),
        .game_service   (game_service)
    );

    board_ctrl board_ctrl_i (
        .clk_sys     (clk_sys),
        .rst         (rst),
        .rst_req     (rst_req),
        .downloading (downloading),
        .key_rise    (key_rise),
        .joy_rise    (joy_rise),
        .dip         (dip_bus.ctrl),
        .game_rst    (game_rst),
        .gfx_en      (gfx_en),
        .dip_pause   (dip_pause)
    );

    // Settings the game core reads directly
    assign dip_flip   = dip_bus.flip;
    assign dip_test   = dip_bus.test;
    assign enable_fm  = dip_bus.enable_fm;
    assign enable_psg = dip_bus.enable_psg;

endmodule

// File: test/board_tests.svh
// Stimulus helpers, reference mapping and directed tests for the board section

// Drive at a falling edge and keep the pause and gfx toggle models in step
task automatic apply_inputs(input joy_pair_t j, input key_state_t k);
    logic pause_rise;
    pause_rise = (k.pause & ~prev_keys.pause)
               | (j.joy1[PAUSE_BIT] & ~prev_joy.joy1[PAUSE_BIT])
               | (j.joy2[PAUSE_BIT] & ~prev_joy.joy2[PAUSE_BIT]);
    if (pause_rise) begin
        pause_model = ~pause_model;
    end
    gfx_model      = gfx_model ^ (k.gfx & ~prev_keys.gfx);
    prev_joy       = j;
    prev_keys      = k;
    board_joystick = j;
    keys           = k;
endtask

// Input to output path is 3 edges and the sample follows on the falling edge
task automatic settle();
    repeat (3) @(posedge clk_sys);
    @(negedge clk_sys);
endtask

// Game side joystick from OR merge, optional quarter turn and inversion
function automatic logic [GAME_JOY_W-1:0] mapped_joy(input logic [JOY_W-1:0] board,
                                                     input logic [GAME_JOY_W-1:0] key,
                                                     input logic rot);
    logic [GAME_JOY_W-1:0] m;
    m = board[GAME_JOY_W-1:0] | key;
    if (rot) begin
        m = {m[GAME_JOY_W-1:4], m[0], m[1], m[3], m[2]};
    end
    return ~m;
endfunction

// Starts at a falling edge and waits edges rising edges up to the trigger edge
task automatic check_rst_hold(input int edges, input string what);
    if (edges > 0) begin
        repeat (edges) @(posedge clk_sys);
        @(negedge clk_sys);
    end
    check_bit(game_rst, 1'b1, {what, ": game_rst after trigger"});
    repeat (GAME_RST_HOLD - 1) @(posedge clk_sys);
    @(negedge clk_sys);
    check_bit(game_rst, 1'b1, {what, ": game_rst before hold end"});
    @(posedge clk_sys);
    @(negedge clk_sys);
    check_bit(game_rst, 1'b0, {what, ": game_rst after hold"});
endtask

task automatic test_reset();
    check_gfx(gfx_en, '1, "gfx_en after reset");
    check_bit(dip_pause, 1'b1, "dip_pause after reset");
    check_joy(game_joystick1, '1, "game_joystick1 after reset");
    check_joy(game_joystick2, '1, "game_joystick2 after reset");
    check_pair(game_coin, 2'b11, "game_coin after reset");
    check_pair(game_start, 2'b11, "game_start after reset");
    check_bit(game_service, 1'b1, "game_service after reset");
    check_bit(dip_flip, 1'b0, "dip_flip after reset");
    check_bit(dip_test, 1'b0, "dip_test after reset");
    check_bit(enable_fm, 1'b1, "enable_fm after reset");
    check_bit(enable_psg, 1'b1, "enable_psg after reset");
    check_rst_hold(0, "rst");   // Last rst edge was just before release
endtask

task automatic test_joystick_map();
    joy_pair_t   j;
    key_state_t  k;
    logic [31:0] r;
    for (int rot = 0; rot < 2; rot++) begin
        status[STATUS_ROT_BIT] = rot[0];
        for (int n = 0; n < VECTORS; n++) begin
            j = joy_pair_t'(rand_word());
            r = rand_word();
            k = '0;
            k.joy1 = r[GAME_JOY_W-1:0];
            k.joy2 = r[2*GAME_JOY_W-1:GAME_JOY_W];
            apply_inputs(j, k);
            settle();
            check_joy(game_joystick1, mapped_joy(j.joy1, k.joy1, rot[0]), "game_joystick1");
            check_joy(game_joystick2, mapped_joy(j.joy2, k.joy2, rot[0]), "game_joystick2");
            check_bit(dip_pause, ~pause_model, "dip_pause from joystick pause");
        end
    end
    status[STATUS_ROT_BIT] = 1'b0;
endtask

task automatic test_coin_start();
    joy_pair_t   j;
    key_state_t  k;
    logic [31:0] r;
    logic [1:0]  exp_coin;
    logic [1:0]  exp_start;
    for (int n = 0; n < VECTORS; n++) begin
        r = rand_word();
        j = '0;
        k = '0;
        j.joy1[START1_BIT] = r[0];
        j.joy1[START2_BIT] = r[1];
        j.joy1[COIN_BIT]   = r[2];
        j.joy2[START1_BIT] = r[3];
        j.joy2[START2_BIT] = r[4];
        j.joy2[COIN_BIT]   = r[5];
        k.start   = r[7:6];
        k.coin    = r[9:8];
        k.service = r[10];
        apply_inputs(j, k);
        settle();
        exp_coin  = ~({j.joy2[COIN_BIT], j.joy1[COIN_BIT]} | k.coin);
        exp_start = ~({j.joy1[START2_BIT] | j.joy2[START2_BIT],
                       j.joy1[START1_BIT] | j.joy2[START1_BIT]} | k.start);
        check_pair(game_coin, exp_coin, "game_coin");
        check_pair(game_start, exp_start, "game_start");
        check_bit(game_service, ~k.service, "game_service");
    end
endtask

// Test mode and the sound disable bits of the status word
task automatic test_settings();
    logic [31:0] r;
    for (int n = 0; n < VECTORS; n++) begin
        r = rand_word();
        status[STATUS_TEST_BIT]    = r[0];
        status[STATUS_FM_OFF_BIT]  = r[1];
        status[STATUS_PSG_OFF_BIT] = r[2];
        settle();
        check_bit(dip_test, r[0], "dip_test");
        check_bit(enable_fm, ~r[1], "enable_fm");
        check_bit(enable_psg, ~r[2], "enable_psg");
    end
    status[STATUS_TEST_BIT]    = 1'b0;
    status[STATUS_FM_OFF_BIT]  = 1'b0;
    status[STATUS_PSG_OFF_BIT] = 1'b0;
endtask

task automatic test_pause();
    joy_pair_t  j;
    key_state_t k;
    apply_inputs('0, '0);
    settle();
    check_bit(dip_pause, ~pause_model, "dip_pause idle");
    k = '0;
    k.pause = 1'b1;
    apply_inputs('0, k);   // Key press toggles
    settle();
    check_bit(dip_pause, ~pause_model, "dip_pause after pause key");
    apply_inputs('0, '0);
    settle();
    check_bit(dip_pause, ~pause_model, "dip_pause after key release");
    j = '0;
    j.joy2[PAUSE_BIT] = 1'b1;
    apply_inputs(j, '0);   // Joystick 2 button toggles back
    settle();
    check_bit(dip_pause, ~pause_model, "dip_pause after joystick 2 pause");
    apply_inputs('0, '0);
    status[STATUS_PAUSE_BIT] = 1'b1;
    settle();
    check_bit(dip_pause, 1'b0, "dip_pause forced by status");
    apply_inputs('0, k);
    settle();
    check_bit(dip_pause, 1'b0, "dip_pause forced with key press");
    apply_inputs('0, '0);
    status[STATUS_PAUSE_BIT] = 1'b0;
    settle();
    check_bit(dip_pause, ~pause_model, "dip_pause after status release");
endtask

task automatic test_gfx();
    key_state_t k;
    for (int i = 0; i < GFX_LAYERS; i++) begin
        k = '0;
        k.gfx[i] = 1'b1;
        apply_inputs('0, k);
        settle();
        check_gfx(gfx_en, gfx_model, "gfx_en after key press");
        apply_inputs('0, '0);
        settle();
        check_gfx(gfx_en, gfx_model, "gfx_en after key release");
    end
endtask

task automatic test_game_rst();
    key_state_t k;
    apply_inputs('0, '0);
    settle();
    check_bit(game_rst, 1'b0, "game_rst idle");
    rst_req = 1'b1;          // One cycle pulse sampled on the next edge
    @(negedge clk_sys);
    rst_req = 1'b0;
    check_rst_hold(0, "rst_req");
    downloading = 1'b1;
    @(negedge clk_sys);
    downloading = 1'b0;
    check_rst_hold(0, "downloading");
    k = '0;
    k.reset = 1'b1;
    apply_inputs('0, k);
    @(negedge clk_sys);
    apply_inputs('0, '0);
    check_rst_hold(2, "reset key");   // Rise seen two edges after capture
    status[STATUS_FLIP_BIT] = 1'b1;
    check_rst_hold(2, "flip change"); // Decoded flip differs on the second edge
    check_bit(dip_flip, 1'b1, "dip_flip after flip change");
endtask

// File: test/board_tb.sv
// Testbench top with clock, reset, DUT, xorshift source, compare tasks and watchdog
module board_tb import board_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 8;
    localparam int VECTORS    = 8;   // Random vectors per pass
    // Reset, five game reset holds, mapping, coin, settings, pause and gfx steps
    localparam int RUN_CYCLES = 16 + 5 * (GAME_RST_HOLD + 8) + 4 * VECTORS * 4
                              + 16 * 4 + GFX_LAYERS * 8 + 200;

    logic                  clk_sys;
    logic                  rst;
    logic                  rst_req;
    logic                  downloading;
    joy_pair_t             board_joystick;
    key_state_t            keys;
    logic [STATUS_W-1:0]   status;
    logic                  game_rst;
    logic [GAME_JOY_W-1:0] game_joystick1;
    logic [GAME_JOY_W-1:0] game_joystick2;
    logic [1:0]            game_coin;
    logic [1:0]            game_start;
    logic                  game_service;
    logic [GFX_LAYERS-1:0] gfx_en;
    logic                  dip_pause;
    logic                  dip_flip;
    logic                  dip_test;
    logic                  enable_fm;
    logic                  enable_psg;

    logic [31:0]           rng_state = 32'he1817116;

    // Expected board state that follows the driven stimulus
    logic                  pause_model = 1'b0;
    logic [GFX_LAYERS-1:0] gfx_model = '1;
    joy_pair_t             prev_joy = '0;
    key_state_t            prev_keys = '0;

    board_top dut_i (
        .clk_sys        (clk_sys),
        .rst            (rst),
        .rst_req        (rst_req),
        .downloading    (downloading),
        .board_joystick (board_joystick),
        .keys           (keys),
        .status         (status),
        .game_rst       (game_rst),
        .game_joystick1 (game_joystick1),
        .game_joystick2 (game_joystick2),
        .game_coin      (game_coin),
        .game_start     (game_start),
        .game_service   (game_service),
        .gfx_en         (gfx_en),
        .dip_pause      (dip_pause),
        .dip_flip       (dip_flip),
        .dip_test       (dip_test),
        .enable_fm      (enable_fm),
        .enable_psg     (enable_psg)
    );

    initial begin
        clk_sys = 1'b0;
        forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
    end

    function automatic logic [31:0] rand_word();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic abort_run();
        $display("sim failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_joy(input logic [GAME_JOY_W-1:0] got,
                             input logic [GAME_JOY_W-1:0] exp, input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_pair(input logic [1:0] got, input logic [1:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_gfx(input logic [GFX_LAYERS-1:0] got,
                             input logic [GFX_LAYERS-1:0] exp, input string what);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    `include "board_tests.svh"

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("watchdog timeout: tests still running after %0d cycles", RUN_CYCLES);
        abort_run();
    end

    initial begin
        rst            = 1'b1;
        rst_req        = 1'b0;
        downloading    = 1'b0;
        board_joystick = '0;
        keys           = '0;
        status         = '0;
        repeat (16) @(posedge clk_sys);
        @(negedge clk_sys);
        rst = 1'b0;
        test_reset();
        test_joystick_map();
        test_coin_start();
        test_settings();
        test_pause();
        test_gfx();
        test_game_rst();
        $display("sim passed");
        $finish;
    end

endmodule

// File: all.f
+incdir+test
verilog/board_pkg.sv
verilog/dip_if.sv
verilog/sample_sync.sv
verilog/dip_decode.sv
verilog/input_mapper.sv
verilog/board_ctrl.sv
verilog/board_top.sv
test/board_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the board testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps \
    --top-module board_tb -f all.f -Mdir obj_dir
./obj_dir/Vboard_tb
